// File: soc_pkg.sv
/*
 * Bus-side definitions shared by the fabric: word and select types,
 * the region map decoded by the address switch and the system ID.
 * Import it wherever bus signals are declared.
 */
package soc_pkg;

	// bus word types
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] sel_t;

	// ------------------------------------------------
	// address map, top four bits select the region
	// ------------------------------------------------
	localparam int SLAVE_FIELD_LSB = 28;
	localparam logic [3:0] REGION_SRAM = 4'h0;
	localparam logic [3:0] REGION_CSR = 4'h6;

	// decoded slave
	typedef enum logic [1:0] {
		SLV_SRAM,
		SLV_CSR,
		SLV_NONE
	} slave_e;

	// returned by the system controller
	localparam data_t SYSTEM_ID = 32'h5343_0102;

endpackage

// File: csr_pkg.sv
/*
 * CSR bus layout: address width, peripheral field and the register
 * indices of the system controller and the UART.
 */
package csr_pkg;

	typedef logic [13:0] csr_addr_t;

	// upper four address bits pick the peripheral
	localparam int CSR_PERIPH_LSB = 10;

	typedef enum logic [3:0] {
		PER_UART = 4'h0,
		PER_SYSCTL = 4'h1
	} periph_e;

	typedef enum logic [2:0] {
		REG_GPIO_IN = 3'd0,
		REG_GPIO_OUT = 3'd1,
		REG_TIMER_CTRL = 3'd2,
		REG_TIMER_COMPARE = 3'd3,
		REG_TIMER_COUNT = 3'd4,
		REG_IRQ_PENDING = 3'd5,
		REG_HARD_RESET = 3'd6,
		REG_SYSTEM_ID = 3'd7
	} sysctl_reg_e;

	typedef enum logic [1:0] {
		REG_UART_DATA = 2'd0,
		REG_UART_STATUS = 2'd1,
		REG_UART_DIVISOR = 2'd2
	} uart_reg_e;

	// transmitter sequence
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_STOP
	} uart_state_e;

endpackage

// File: wb_if.sv
/*
 * One bus segment between the address switch and a slave.
 * The switch takes the master modport, the slave the slave modport.
 */
`timescale 1ns/1ps

interface wb_if;
	import soc_pkg::*;

	addr_t adr;
	data_t dat_w;
	data_t dat_r;
	sel_t sel;
	logic we;
	logic stb;
	logic ack;

	modport master (output adr, dat_w, sel, we, stb, input dat_r, ack);
	modport slave (input adr, dat_w, sel, we, stb, output dat_r, ack);
endinterface

// File: reset_gen.sv
/*
 * System reset stretcher. Any external or software reset request
 * reloads the hold counter; sys_rst_o stays high until RST_HOLD
 * cycles after the last request.
 */
`timescale 1ns/1ps

module reset_gen #(
	parameter int RST_HOLD = 16
) (
	input logic sys_clk,
	input logic trigger_reset,
	input logic hard_reset_i,
	output logic sys_rst_o
);
	localparam int CNT_W = $clog2(RST_HOLD + 1);

	logic [CNT_W-1:0] hold_cnt;

	always_ff @(posedge sys_clk) begin
		// reload on every request, count down otherwise
		if (trigger_reset || hard_reset_i)
			hold_cnt <= CNT_W'(RST_HOLD);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
		// registered from the busy flag
		sys_rst_o <= (hold_cnt != '0);
	end
endmodule

// File: bus_switch.sv
/*
 * Address switch for the single external master. The region field
 * selects the scratch RAM or the CSR bridge; any other region gets
 * a local ack with err set and zero read data.
 */
`timescale 1ns/1ps

module bus_switch (
	input logic sys_clk,
	input logic sys_rst_i,
	input logic ext_stb_i,
	input logic ext_we_i,
	input soc_pkg::addr_t ext_adr_i,
	input soc_pkg::data_t ext_dat_i,
	input soc_pkg::sel_t ext_sel_i,
	output soc_pkg::data_t ext_dat_o,
	output logic ext_ack_o,
	output logic ext_err_o,
	wb_if.master sram_bus,
	wb_if.master csr_bus
);
	import soc_pkg::*;

	slave_e slave_sel;
	logic none_ack;

	// region decode
	always_comb begin
		case (ext_adr_i[SLAVE_FIELD_LSB +: 4])
			REGION_SRAM: slave_sel = SLV_SRAM;
			REGION_CSR: slave_sel = SLV_CSR;
			default: slave_sel = SLV_NONE;
		endcase
	end

	// ------------------------------------------------
	// request side, strobe only to the chosen slave
	// ------------------------------------------------
	assign sram_bus.adr = ext_adr_i;
	assign sram_bus.dat_w = ext_dat_i;
	assign sram_bus.sel = ext_sel_i;
	assign sram_bus.we = ext_we_i;
	assign sram_bus.stb = ext_stb_i && (slave_sel == SLV_SRAM);

	assign csr_bus.adr = ext_adr_i;
	assign csr_bus.dat_w = ext_dat_i;
	assign csr_bus.sel = ext_sel_i;
	assign csr_bus.we = ext_we_i;
	assign csr_bus.stb = ext_stb_i && (slave_sel == SLV_CSR);

	// unmapped region, one-cycle error ack
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			none_ack <= 1'b0;
		else
			none_ack <= ext_stb_i && (slave_sel == SLV_NONE) && !none_ack;
	end

	// ------------------------------------------------
	// response side
	// ------------------------------------------------
	always_comb begin
		ext_dat_o = '0;
		ext_ack_o = 1'b0;
		ext_err_o = 1'b0;
		case (slave_sel)
			SLV_SRAM: begin
				ext_dat_o = sram_bus.dat_r;
				ext_ack_o = sram_bus.ack;
			end
			SLV_CSR: begin
				ext_dat_o = csr_bus.dat_r;
				ext_ack_o = csr_bus.ack;
			end
			default: begin
				// err only ever with ack
				ext_ack_o = none_ack;
				ext_err_o = none_ack;
			end
		endcase
	end
endmodule

// File: sram_slave.sv
/*
 * On-chip scratch RAM on the bus, word addressed, byte writes under
 * the select lanes. Acks one cycle after the strobe is seen.
 */
`timescale 1ns/1ps

module sram_slave #(
	parameter int SRAM_AW = 8
) (
	input logic sys_clk,
	input logic sys_rst_i,
	wb_if.slave bus
);
	import soc_pkg::*;

	data_t mem [2**SRAM_AW];
	logic [SRAM_AW-1:0] word_idx;
	logic req;

	// byte address to word index
	assign word_idx = bus.adr[2 +: SRAM_AW];
	// new access, not the ack cycle of the previous one
	assign req = bus.stb && !bus.ack;

	always_ff @(posedge sys_clk) begin
		if (req && bus.we) begin
			for (int b = 0; b < 4; b++) begin
				if (bus.sel[b])
					mem[word_idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
			end
		end
		bus.dat_r <= mem[word_idx];
	end

	// self-clearing ack
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			bus.ack <= 1'b0;
		else
			bus.ack <= req;
	end
endmodule

// File: csr_bridge.sv
/*
 * Bus to CSR bridge. First cycle drives the CSR address, data and a
 * one-cycle write strobe; second cycle latches the ORed peripheral
 * read data and acks the bus.
 */
`timescale 1ns/1ps

module csr_bridge (
	input logic sys_clk,
	input logic sys_rst_i,
	wb_if.slave bus,
	output csr_pkg::csr_addr_t csr_a_o,
	output logic csr_we_o,
	output soc_pkg::data_t csr_dw_o,
	input soc_pkg::data_t csr_dr_uart_i,
	input soc_pkg::data_t csr_dr_sysctl_i
);
	import soc_pkg::*;
	import csr_pkg::*;

	typedef enum logic {
		BRG_IDLE,
		BRG_DATA
	} brg_state_e;

	brg_state_e state;

	always_ff @(posedge sys_clk) begin
		// strobes default low
		csr_we_o <= 1'b0;
		bus.ack <= 1'b0;
		if (sys_rst_i) begin
			state <= BRG_IDLE;
		end else begin
			case (state)
				BRG_IDLE: begin
					// skip the ack cycle of the last access
					if (bus.stb && !bus.ack) begin
						csr_a_o <= bus.adr[2 +: $bits(csr_addr_t)];
						csr_dw_o <= bus.dat_w;
						csr_we_o <= bus.we;
						state <= BRG_DATA;
					end
				end
				BRG_DATA: begin
					// unselected peripherals return zero
					bus.dat_r <= csr_dr_uart_i | csr_dr_sysctl_i;
					bus.ack <= 1'b1;
					state <= BRG_IDLE;
				end
				default: state <= BRG_IDLE;
			endcase
		end
	end
endmodule

// File: sysctl.sv
/*
 * System controller on the CSR bus: button inputs with change
 * interrupt, one LED, a compare timer, interrupt pending bits,
 * the system ID and a software hard reset request.
 */
`timescale 1ns/1ps

module sysctl #(
	parameter int GPIO_IN_W = 3
) (
	input logic sys_clk,
	input logic sys_rst_i,
	input csr_pkg::csr_addr_t csr_a_i,
	input logic csr_we_i,
	input soc_pkg::data_t csr_dw_i,
	output soc_pkg::data_t csr_dr_o,
	input logic [GPIO_IN_W-1:0] gpio_i,
	output logic led_o,
	output logic gpio_irq_o,
	output logic timer_irq_o,
	output logic hard_reset_o
);
	import soc_pkg::*;
	import csr_pkg::*;

	logic [GPIO_IN_W-1:0] gpio_meta;
	logic [GPIO_IN_W-1:0] gpio_sync;
	logic [GPIO_IN_W-1:0] gpio_prev;
	logic csr_sel;
	logic csr_wr;
	sysctl_reg_e reg_idx;
	logic timer_en;
	logic timer_hit;
	data_t timer_cnt;
	data_t timer_cmp;

	// peripheral field match, unused index bits must be zero
	assign csr_sel = (csr_a_i[CSR_PERIPH_LSB +: 4] == PER_SYSCTL)
		&& (csr_a_i[CSR_PERIPH_LSB-1:3] == '0);
	assign csr_wr = csr_sel && csr_we_i;
	assign reg_idx = sysctl_reg_e'(csr_a_i[2:0]);
	assign timer_hit = timer_en && (timer_cnt == timer_cmp);

	// two-stage button sync, plus previous value for edge detect
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_i;
		gpio_sync <= gpio_meta;
		gpio_prev <= gpio_sync;
	end

	// ------------------------------------------------
	// registers, timer and pending bits
	// ------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led_o <= 1'b0;
			timer_en <= 1'b0;
			timer_cnt <= '0;
			timer_cmp <= '0;
			gpio_irq_o <= 1'b0;
			timer_irq_o <= 1'b0;
			hard_reset_o <= 1'b0;
		end else begin
			// single-cycle request to the reset generator
			hard_reset_o <= csr_wr && (reg_idx == REG_HARD_RESET);
			if (csr_wr && (reg_idx == REG_GPIO_OUT))
				led_o <= csr_dw_i[0];
			if (csr_wr && (reg_idx == REG_TIMER_COMPARE))
				timer_cmp <= csr_dw_i;
			// control write restarts the count
			if (csr_wr && (reg_idx == REG_TIMER_CTRL)) begin
				timer_en <= csr_dw_i[0];
				timer_cnt <= '0;
			end else if (csr_wr && (reg_idx == REG_TIMER_COUNT)) begin
				timer_cnt <= csr_dw_i;
			end else if (timer_hit) begin
				timer_cnt <= '0;
			end else if (timer_en) begin
				timer_cnt <= timer_cnt + 1'b1;
			end
			// write one to clear, a new event wins
			if (csr_wr && (reg_idx == REG_IRQ_PENDING)) begin
				if (csr_dw_i[0])
					gpio_irq_o <= 1'b0;
				if (csr_dw_i[1])
					timer_irq_o <= 1'b0;
			end
			if (gpio_sync != gpio_prev)
				gpio_irq_o <= 1'b1;
			if (timer_hit)
				timer_irq_o <= 1'b1;
		end
	end

	// read mux, zero when not addressed
	always_comb begin
		csr_dr_o = '0;
		if (csr_sel) begin
			case (reg_idx)
				REG_GPIO_IN: csr_dr_o = data_t'(gpio_sync);
				REG_GPIO_OUT: csr_dr_o = {31'd0, led_o};
				REG_TIMER_CTRL: csr_dr_o = {31'd0, timer_en};
				REG_TIMER_COMPARE: csr_dr_o = timer_cmp;
				REG_TIMER_COUNT: csr_dr_o = timer_cnt;
				REG_IRQ_PENDING: csr_dr_o = {30'd0, timer_irq_o, gpio_irq_o};
				REG_HARD_RESET: csr_dr_o = '0;
				REG_SYSTEM_ID: csr_dr_o = SYSTEM_ID;
			endcase
		end
	end
endmodule

// File: uart_tx.sv
/*
 * Transmit-only UART on the CSR bus. A data write while idle sends
 * one 8N1 frame, LSB first, each bit lasting divisor cycles.
 * Status: bit 0 busy, bit 1 done pending (write one to clear).
 */
`timescale 1ns/1ps

module uart_tx #(
	parameter int UART_DIV = 8
) (
	input logic sys_clk,
	input logic sys_rst_i,
	input csr_pkg::csr_addr_t csr_a_i,
	input logic csr_we_i,
	input soc_pkg::data_t csr_dw_i,
	output soc_pkg::data_t csr_dr_o,
	output logic tx_o,
	output logic irq_o
);
	import soc_pkg::*;
	import csr_pkg::*;

	uart_state_e state;
	uart_reg_e reg_idx;
	logic csr_sel;
	logic csr_wr;
	logic busy;
	logic [15:0] divisor;
	logic [15:0] div_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shreg;

	assign csr_sel = (csr_a_i[CSR_PERIPH_LSB +: 4] == PER_UART)
		&& (csr_a_i[CSR_PERIPH_LSB-1:2] == '0);
	assign csr_wr = csr_sel && csr_we_i;
	assign reg_idx = uart_reg_e'(csr_a_i[1:0]);
	assign busy = (state != ST_IDLE);

	// ------------------------------------------------
	// frame sequencer
	// ------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= ST_IDLE;
			tx_o <= 1'b1;
			irq_o <= 1'b0;
			divisor <= 16'(UART_DIV);
		end else begin
			if (csr_wr && (reg_idx == REG_UART_STATUS) && csr_dw_i[1])
				irq_o <= 1'b0;
			if (csr_wr && (reg_idx == REG_UART_DIVISOR))
				divisor <= csr_dw_i[15:0];
			case (state)
				ST_IDLE: begin
					// data writes while busy are dropped
					if (csr_wr && (reg_idx == REG_UART_DATA)) begin
						shreg <= csr_dw_i[7:0];
						tx_o <= 1'b0;
						div_cnt <= divisor - 1'b1;
						state <= ST_START;
					end
				end
				ST_START: begin
					if (div_cnt == '0) begin
						tx_o <= shreg[0];
						shreg <= shreg >> 1;
						bit_cnt <= '0;
						div_cnt <= divisor - 1'b1;
						state <= ST_DATA;
					end else begin
						div_cnt <= div_cnt - 1'b1;
					end
				end
				ST_DATA: begin
					if (div_cnt != '0) begin
						div_cnt <= div_cnt - 1'b1;
					end else if (bit_cnt == 3'd7) begin
						// last data bit done, stop bit
						tx_o <= 1'b1;
						div_cnt <= divisor - 1'b1;
						state <= ST_STOP;
					end else begin
						tx_o <= shreg[0];
						shreg <= shreg >> 1;
						bit_cnt <= bit_cnt + 1'b1;
						div_cnt <= divisor - 1'b1;
					end
				end
				ST_STOP: begin
					if (div_cnt == '0) begin
						irq_o <= 1'b1;
						state <= ST_IDLE;
					end else begin
						div_cnt <= div_cnt - 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_comb begin
		csr_dr_o = '0;
		if (csr_sel) begin
			case (reg_idx)
				REG_UART_STATUS: csr_dr_o = {30'd0, irq_o, busy};
				REG_UART_DIVISOR: csr_dr_o = {16'd0, divisor};
				default: csr_dr_o = '0;
			endcase
		end
	end
endmodule

// File: soc_top.sv
/*
 * Top level of the bus fabric. One external bus master reaches the
 * scratch RAM and, through the CSR bridge, the system controller and
 * the UART. irq_o bit 0 is the UART, bit 1 GPIO, bit 2 the timer.
 */
`timescale 1ns/1ps

module soc_top #(
	parameter int RST_HOLD = 16,
	parameter int SRAM_AW = 8,
	parameter int UART_DIV = 8,
	parameter int GPIO_IN_W = 3
) (
	input logic sys_clk,
	input logic trigger_reset,
	input logic wb_stb_i,
	input logic wb_we_i,
	input soc_pkg::addr_t wb_adr_i,
	input soc_pkg::data_t wb_dat_i,
	input soc_pkg::sel_t wb_sel_i,
	output soc_pkg::data_t wb_dat_o,
	output logic wb_ack_o,
	output logic wb_err_o,
	input logic [GPIO_IN_W-1:0] btn_i,
	output logic led_o,
	output logic uart_tx_o,
	output logic [2:0] irq_o
);
	import soc_pkg::*;
	import csr_pkg::*;

	logic sys_rst;
	logic hard_reset;
	csr_addr_t csr_a;
	logic csr_we;
	data_t csr_dw;
	data_t csr_dr_uart;
	data_t csr_dr_sysctl;

	wb_if sram_bus ();
	wb_if csr_bus ();

	// ------------------------------------------------
	// reset and bus fabric
	// ------------------------------------------------
	reset_gen #(.RST_HOLD(RST_HOLD)) reset_gen_i (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.hard_reset_i(hard_reset),
		.sys_rst_o(sys_rst)
	);

	bus_switch bus_switch_i (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.ext_stb_i(wb_stb_i),
		.ext_we_i(wb_we_i),
		.ext_adr_i(wb_adr_i),
		.ext_dat_i(wb_dat_i),
		.ext_sel_i(wb_sel_i),
		.ext_dat_o(wb_dat_o),
		.ext_ack_o(wb_ack_o),
		.ext_err_o(wb_err_o),
		.sram_bus(sram_bus.master),
		.csr_bus(csr_bus.master)
	);

	sram_slave #(.SRAM_AW(SRAM_AW)) sram_slave_i (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.bus(sram_bus.slave)
	);

	csr_bridge csr_bridge_i (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.bus(csr_bus.slave),
		.csr_a_o(csr_a),
		.csr_we_o(csr_we),
		.csr_dw_o(csr_dw),
		.csr_dr_uart_i(csr_dr_uart),
		.csr_dr_sysctl_i(csr_dr_sysctl)
	);

	// ------------------------------------------------
	// CSR peripherals
	// ------------------------------------------------
	sysctl #(.GPIO_IN_W(GPIO_IN_W)) sysctl_i (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr_a_i(csr_a),
		.csr_we_i(csr_we),
		.csr_dw_i(csr_dw),
		.csr_dr_o(csr_dr_sysctl),
		.gpio_i(btn_i),
		.led_o(led_o),
		.gpio_irq_o(irq_o[1]),
		.timer_irq_o(irq_o[2]),
		.hard_reset_o(hard_reset)
	);

	uart_tx #(.UART_DIV(UART_DIV)) uart_tx_i (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr_a_i(csr_a),
		.csr_we_i(csr_we),
		.csr_dw_i(csr_dw),
		.csr_dr_o(csr_dr_uart),
		.tx_o(uart_tx_o),
		.irq_o(irq_o[0])
	);
endmodule

// File: soc_props.sv
/*
 * Bus handshake and reset assertions for the fabric top level.
 * Bound into soc_top below, so every instance gets them.
 */
`timescale 1ns/1ps

module soc_props (
	input logic sys_clk,
	input logic sys_rst_i,
	input logic stb_i,
	input logic ack_i,
	input logic err_i,
	input logic [2:0] irq_i,
	input logic tx_i
);
	// failed assertions so far
	int fail_cnt = 0;

	// ack only answers a pending strobe
	ack_needs_stb: assert property (@(posedge sys_clk) ack_i |-> stb_i)
		else begin
			$error("ack seen without stb");
			fail_cnt++;
		end

	// err is a qualifier of ack, never alone
	err_needs_ack: assert property (@(posedge sys_clk) err_i |-> ack_i)
		else begin
			$error("err seen without ack");
			fail_cnt++;
		end

	// one ack per access
	ack_one_cycle: assert property (@(posedge sys_clk) ack_i |=> !ack_i)
		else begin
			$error("ack longer than one cycle");
			fail_cnt++;
		end

	// ------------------------------------------------
	// quiet outputs once reset has taken hold
	// ------------------------------------------------
	quiet_in_reset: assert property (@(posedge sys_clk)
		(sys_rst_i && $past(sys_rst_i)) |-> (!ack_i && irq_i == 3'b000 && tx_i))
		else begin
			$error("ack, irq or uart line active during reset");
			fail_cnt++;
		end
endmodule

bind soc_top soc_props props_i (
	.sys_clk(sys_clk),
	.sys_rst_i(sys_rst),
	.stb_i(wb_stb_i),
	.ack_i(wb_ack_o),
	.err_i(wb_err_o),
	.irq_i(irq_o),
	.tx_i(uart_tx_o)
);

// File: tb_soc_top.sv
/*
 * Testbench for the bus fabric top level. A table of bus accesses,
 * pin checks, timer and UART steps is built at time zero and then
 * applied row by row; soc_props rides along inside the DUT.
 */
`timescale 1ns/1ps

module tb_soc_top;
	import soc_pkg::*;
	import csr_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RST_HOLD = 16;
	localparam int SRAM_AW = 8;
	localparam int UART_DIV = 8;
	localparam int GPIO_IN_W = 3;
	localparam int RAM_WORDS = 4;
	localparam int TIMER_CMP = 20;
	localparam int TB_DIV = 6;

	// row kinds
	typedef enum logic [2:0] {
		OP_WR,
		OP_RD,
		OP_BTN,
		OP_PINS,
		OP_TIMER,
		OP_UART,
		OP_WAIT
	} op_e;

	// exp doubles as the pin pattern for OP_PINS and the divisor for OP_UART
	typedef struct packed {
		op_e op;
		addr_t adr;
		data_t dat;
		sel_t sel;
		data_t exp;
		logic err;
	} row_t;

	logic sys_clk;
	logic trigger_reset;
	logic wb_stb_i;
	logic wb_we_i;
	addr_t wb_adr_i;
	data_t wb_dat_i;
	sel_t wb_sel_i;
	data_t wb_dat_o;
	logic wb_ack_o;
	logic wb_err_o;
	logic [GPIO_IN_W-1:0] btn_i;
	logic led_o;
	logic uart_tx_o;
	logic [2:0] irq_o;

	row_t rows[$];
	addr_t ram_adr [RAM_WORDS];
	data_t ram_exp [RAM_WORDS];
	int errors;
	int checks;
	logic table_ready;

	soc_top #(
		.RST_HOLD(RST_HOLD),
		.SRAM_AW(SRAM_AW),
		.UART_DIV(UART_DIV),
		.GPIO_IN_W(GPIO_IN_W)
	) dut_i (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_sel_i(wb_sel_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.wb_err_o(wb_err_o),
		.btn_i(btn_i),
		.led_o(led_o),
		.uart_tx_o(uart_tx_o),
		.irq_o(irq_o)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	// ------------------------------------------------
	// helpers
	// ------------------------------------------------
	task automatic compare_value(input string what, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0d ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// byte lanes with sel set take the new word
	function automatic data_t merge_bytes(data_t old_word, data_t new_word, sel_t sel);
		data_t res;
		res = old_word;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		end
		return res;
	endfunction

	// region 6, peripheral in csr bits 13:10, word address shifted to bytes
	function automatic addr_t csr_addr(periph_e per, int idx);
		csr_addr_t word;
		word = (csr_addr_t'(per) << CSR_PERIPH_LSB) | csr_addr_t'(idx);
		return (addr_t'(REGION_CSR) << SLAVE_FIELD_LSB) | (addr_t'(word) << 2);
	endfunction

	function automatic void add_row(op_e op, addr_t adr, data_t dat, sel_t sel,
			data_t exp, logic err);
		row_t r;
		r.op = op;
		r.adr = adr;
		r.dat = dat;
		r.sel = sel;
		r.exp = exp;
		r.err = err;
		rows.push_back(r);
	endfunction

	// one access, held until ack, stb dropped in the cycle after
	task automatic bus_access(input logic we, input addr_t adr, input data_t dat,
			input sel_t sel, output data_t rdata, output logic err);
		@(posedge sys_clk);
		wb_stb_i <= 1'b1;
		wb_we_i <= we;
		wb_adr_i <= adr;
		wb_dat_i <= dat;
		wb_sel_i <= sel;
		do @(negedge sys_clk); while (wb_ack_o !== 1'b1);
		rdata = wb_dat_o;
		err = wb_err_o;
		@(posedge sys_clk);
		wb_stb_i <= 1'b0;
		wb_we_i <= 1'b0;
	endtask

	// 8N1 receiver, samples near the middle of each bit
	task automatic decode_serial(input int div, output logic [7:0] rx,
			output logic frame_ok);
		do @(negedge sys_clk); while (uart_tx_o !== 1'b0);
		repeat (div / 2) @(negedge sys_clk);
		frame_ok = (uart_tx_o === 1'b0);
		for (int i = 0; i < 8; i++) begin
			repeat (div) @(negedge sys_clk);
			rx[i] = uart_tx_o;
		end
		repeat (div) @(negedge sys_clk);
		frame_ok = frame_ok && (uart_tx_o === 1'b1);
	endtask

	task automatic wait_irq(input int idx, input int max_cycles, output logic seen);
		seen = 1'b0;
		for (int n = 0; n < max_cycles && !seen; n++) begin
			@(negedge sys_clk);
			seen = (irq_o[idx] === 1'b1);
		end
	endtask

	task automatic apply_row(input row_t r);
		data_t rdata;
		logic err;
		logic [7:0] rx;
		logic frame_ok;
		logic seen;
		case (r.op)
			OP_WR: begin
				bus_access(1'b1, r.adr, r.dat, r.sel, rdata, err);
				compare_value($sformatf("write err at %h", r.adr), data_t'(err), data_t'(r.err));
			end
			OP_RD: begin
				bus_access(1'b0, r.adr, r.dat, r.sel, rdata, err);
				compare_value($sformatf("read data at %h", r.adr), rdata, r.exp);
				compare_value($sformatf("read err at %h", r.adr), data_t'(err), data_t'(r.err));
			end
			OP_BTN: begin
				@(posedge sys_clk);
				btn_i <= r.dat[GPIO_IN_W-1:0];
				// two sync stages plus the edge detect
				repeat (4) @(posedge sys_clk);
			end
			OP_PINS: begin
				@(negedge sys_clk);
				compare_value("led and irq pins", {28'd0, led_o, irq_o}, r.exp);
			end
			OP_TIMER: begin
				// counted from the return of the control write
				repeat (int'(r.dat) - 1) @(negedge sys_clk);
				compare_value("timer irq before compare", data_t'(irq_o[2]), 32'd0);
				wait_irq(2, 7, seen);
				compare_value("timer irq after compare", data_t'(seen), 32'd1);
			end
			OP_UART: begin
				fork
					bus_access(1'b1, r.adr, r.dat, r.sel, rdata, err);
					decode_serial(int'(r.exp), rx, frame_ok);
				join
				compare_value("uart byte", data_t'(rx), data_t'(r.dat[7:0]));
				compare_value("uart start and stop bits", data_t'(frame_ok), 32'd1);
				compare_value("uart irq inside frame", data_t'(irq_o[0]), 32'd0);
				wait_irq(0, int'(r.exp) + 2, seen);
				compare_value("uart irq after frame", data_t'(seen), 32'd1);
			end
			OP_WAIT: repeat (int'(r.dat)) @(posedge sys_clk);
			default: ;
		endcase
	endtask

	// ------------------------------------------------
	// table build, reset and run
	// ------------------------------------------------
	initial begin
		data_t first_word;
		data_t second_word;
		sel_t lanes;
		data_t uart_byte;
		sys_clk = 1'b0;
		trigger_reset = 1'b1;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_sel_i = '0;
		btn_i = '0;
		errors = 0;
		checks = 0;
		table_ready = 1'b0;
		void'($urandom(32'h7539_bc5f));

		// ram: full write, partial write, merged read back
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram_adr[i] = addr_t'(i * 64 + ($urandom % 16) * 4);
			first_word = $urandom;
			second_word = $urandom;
			lanes = sel_t'($urandom);
			ram_exp[i] = merge_bytes(first_word, second_word, lanes);
			add_row(OP_WR, ram_adr[i], first_word, 4'hF, '0, 1'b0);
			add_row(OP_WR, ram_adr[i], second_word, lanes, '0, 1'b0);
			add_row(OP_RD, ram_adr[i], '0, 4'hF, ram_exp[i], 1'b0);
		end
		// unmapped regions
		add_row(OP_RD, 32'h3000_0010, '0, 4'hF, '0, 1'b1);
		add_row(OP_WR, 32'hF000_0000, 32'hDEAD_BEEF, 4'hF, '0, 1'b1);
		add_row(OP_RD, 32'hF000_0040, '0, 4'hF, '0, 1'b1);
		// sysctl id, buttons, pending clear, led
		add_row(OP_RD, csr_addr(PER_SYSCTL, REG_SYSTEM_ID), '0, 4'hF, SYSTEM_ID, 1'b0);
		add_row(OP_BTN, '0, 32'd5, 4'hF, '0, 1'b0);
		add_row(OP_RD, csr_addr(PER_SYSCTL, REG_GPIO_IN), '0, 4'hF, 32'd5, 1'b0);
		add_row(OP_PINS, '0, '0, 4'hF, 32'b0010, 1'b0);
		add_row(OP_WR, csr_addr(PER_SYSCTL, REG_IRQ_PENDING), 32'd1, 4'hF, '0, 1'b0);
		add_row(OP_PINS, '0, '0, 4'hF, 32'b0000, 1'b0);
		add_row(OP_WR, csr_addr(PER_SYSCTL, REG_GPIO_OUT), 32'd1, 4'hF, '0, 1'b0);
		add_row(OP_PINS, '0, '0, 4'hF, 32'b1000, 1'b0);
		add_row(OP_RD, csr_addr(PER_SYSCTL, REG_GPIO_OUT), '0, 4'hF, 32'd1, 1'b0);
		// timer, stopped and cleared once it fired
		add_row(OP_WR, csr_addr(PER_SYSCTL, REG_TIMER_COMPARE), TIMER_CMP, 4'hF, '0, 1'b0);
		add_row(OP_RD, csr_addr(PER_SYSCTL, REG_TIMER_COMPARE), '0, 4'hF, TIMER_CMP, 1'b0);
		add_row(OP_WR, csr_addr(PER_SYSCTL, REG_TIMER_CTRL), 32'd1, 4'hF, '0, 1'b0);
		add_row(OP_TIMER, '0, TIMER_CMP, 4'hF, '0, 1'b0);
		add_row(OP_WR, csr_addr(PER_SYSCTL, REG_TIMER_CTRL), 32'd0, 4'hF, '0, 1'b0);
		add_row(OP_WR, csr_addr(PER_SYSCTL, REG_IRQ_PENDING), 32'd2, 4'hF, '0, 1'b0);
		add_row(OP_PINS, '0, '0, 4'hF, 32'b1000, 1'b0);
		// uart frame, then done pending
		uart_byte = $urandom & 32'hFF;
		add_row(OP_WR, csr_addr(PER_UART, REG_UART_DIVISOR), TB_DIV, 4'hF, '0, 1'b0);
		add_row(OP_RD, csr_addr(PER_UART, REG_UART_DIVISOR), '0, 4'hF, TB_DIV, 1'b0);
		add_row(OP_UART, csr_addr(PER_UART, REG_UART_DATA), uart_byte, 4'hF, TB_DIV, 1'b0);
		add_row(OP_RD, csr_addr(PER_UART, REG_UART_STATUS), '0, 4'hF, 32'd2, 1'b0);
		add_row(OP_PINS, '0, '0, 4'hF, 32'b1001, 1'b0);
		add_row(OP_WR, csr_addr(PER_UART, REG_UART_STATUS), 32'd2, 4'hF, '0, 1'b0);
		add_row(OP_PINS, '0, '0, 4'hF, 32'b1000, 1'b0);
		// software hard reset keeps ram, resets registers
		add_row(OP_WR, csr_addr(PER_SYSCTL, REG_HARD_RESET), 32'd1, 4'hF, '0, 1'b0);
		add_row(OP_WAIT, '0, RST_HOLD + 4, 4'hF, '0, 1'b0);
		add_row(OP_PINS, '0, '0, 4'hF, 32'b0000, 1'b0);
		for (int i = 0; i < RAM_WORDS; i++)
			add_row(OP_RD, ram_adr[i], '0, 4'hF, ram_exp[i], 1'b0);
		add_row(OP_RD, csr_addr(PER_UART, REG_UART_DIVISOR), '0, 4'hF, UART_DIV, 1'b0);
		table_ready = 1'b1;

		repeat (4) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		repeat (RST_HOLD + 4) @(posedge sys_clk);

		foreach (rows[n])
			apply_row(rows[n]);
		repeat (4) @(posedge sys_clk);

		$display("checks %0d, check errors %0d, assertion failures %0d",
			checks, errors, dut_i.props_i.fail_cnt);
		if (errors == 0 && dut_i.props_i.fail_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// watchdog, 20 cycles per row plus three frames at the reset divisor
	initial begin
		int limit;
		wait (table_ready);
		limit = rows.size() * 20 + 3 * 10 * UART_DIV;
		repeat (limit) @(posedge sys_clk);
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("sim failed");
		$finish;
	end
endmodule

// File: soc_top.f
soc_pkg.sv
csr_pkg.sv
wb_if.sv
reset_gen.sv
bus_switch.sv
sram_slave.sv
csr_bridge.sv
sysctl.sv
uart_tx.sv
soc_top.sv
soc_props.sv
tb_soc_top.sv

// File: Makefile
# Verilator build and run of the soc_top testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_top -f soc_top.f
	./obj_dir/Vtb_soc_top +verilator+error+limit+100 | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
